//--- design/cpuPkg.sv
// package: word and opcode types, control bit positions, instruction union
package cpuPkg;

        // data, address and instruction words share one width
        typedef logic [15:0] wordT;
        typedef logic [2:0]  regIdxT;
        typedef logic [4:0]  opcodeT;
        typedef logic [1:0]  aluFuncT;

        //////////////////////////////
        // opcodes, bits 15..11
        localparam opcodeT opHalt = 5'b00000;
        localparam opcodeT opNop  = 5'b00001;
        localparam opcodeT opAddi = 5'b01000;
        localparam opcodeT opBeqz = 5'b01100;
        localparam opcodeT opSt   = 5'b10000;
        localparam opcodeT opLd   = 5'b10001;
        localparam opcodeT opLbi  = 5'b11000;
        // R-format group, op picked by func
        localparam opcodeT opAlu  = 5'b11011;

        localparam aluFuncT funcAdd = 2'b00;
        localparam aluFuncT funcSub = 2'b01;

        // bubble word for IF/ID
        localparam wordT nopWord = {opNop, 11'd0};

        //////////////////////////////
        // control vector, bit positions
        localparam int CtrlW        = 7;
        localparam int ctrlRegWrite = 0;
        localparam int ctrlMemRead  = 1;
        localparam int ctrlMemWrite = 2;
        localparam int ctrlBranch   = 3;
        localparam int ctrlSub      = 4;
        localparam int ctrlUseImm   = 5;
        // halt marker, rides down to writeback
        localparam int ctrlHalt     = 6;

        // one instruction word, R and I views
        typedef union packed {
                struct packed {
                        opcodeT  opcode;
                        regIdxT  rs;
                        regIdxT  rt;
                        regIdxT  rd;
                        aluFuncT func;
                } rFields;
                struct packed {
                        opcodeT     opcode;
                        regIdxT     rs;
                        regIdxT     rd;
                        logic [4:0] imm;
                } iFields;
        } instrU;

endpackage

//--- design/decodeStage.sv
// control decode, register file, hazard interlock and ID/EX register of the decode stage
`timescale 1ns/1ns
module decodeStage (
        input  logic                     clk,
        input  logic                     arstN,
        input  cpuPkg::wordT             ifInstr,
        input  cpuPkg::wordT             ifPcNext,
        input  logic                     flush,
        input  logic                     wbValid,
        input  cpuPkg::regIdxT           wbReg,
        input  cpuPkg::wordT             wbData,
        output logic                     stall,
        output logic                     haltSeen,
        output logic                     illegalOp,
        output cpuPkg::wordT             exOpA,
        output cpuPkg::wordT             exOpB,
        output cpuPkg::wordT             exImm,
        output cpuPkg::wordT             exPcNext,
        output cpuPkg::regIdxT           exRd,
        output logic [cpuPkg::CtrlW-1:0] exCtrl
);
        import cpuPkg::*;

        instrU            ins;
        opcodeT           op;
        regIdxT           srcA;
        regIdxT           srcB;
        regIdxT           dest;
        logic             useA;
        logic             useB;
        logic             illegal;
        logic [CtrlW-1:0] ctrl;
        wordT             imm;
        wordT             imm8;
        wordT             regs [8];
        // copy of the EX/MEM destination
        regIdxT           memRdShadow;
        logic             memWrShadow;

        assign ins  = ifInstr;
        assign op   = ins.rFields.opcode;
        assign srcA = ins.rFields.rs;
        // rt of the R view is also the store data slot of the I view
        assign srcB = ins.rFields.rt;
        // LBI and BEQZ immediate from the low byte of the R view
        assign imm8 = {{8{ins.rFields.rt[2]}}, ins.rFields.rt, ins.rFields.rd, ins.rFields.func};

        //////////////////////////////
        // control decode
        always_comb begin
                ctrl    = '0;
                dest    = ins.iFields.rd;
                imm     = {{11{ins.iFields.imm[4]}}, ins.iFields.imm};
                useA    = 1'b0;
                useB    = 1'b0;
                illegal = 1'b0;
                case (op)
                opNop: begin
                end
                opHalt: begin
                        ctrl[ctrlHalt] = 1'b1;
                end
                opLbi: begin
                        // operand A left at zero
                        dest               = ins.rFields.rs;
                        imm                = imm8;
                        ctrl[ctrlRegWrite] = 1'b1;
                        ctrl[ctrlUseImm]   = 1'b1;
                end
                opAddi: begin
                        useA               = 1'b1;
                        ctrl[ctrlRegWrite] = 1'b1;
                        ctrl[ctrlUseImm]   = 1'b1;
                end
                opAlu: begin
                        dest               = ins.rFields.rd;
                        useA               = 1'b1;
                        useB               = 1'b1;
                        ctrl[ctrlRegWrite] = 1'b1;
                        ctrl[ctrlSub]      = (ins.rFields.func == funcSub);
                        if (ins.rFields.func != funcAdd && ins.rFields.func != funcSub) begin
                                illegal        = 1'b1;
                                ctrl           = '0;
                                ctrl[ctrlHalt] = 1'b1;
                        end
                end
                opLd: begin
                        useA               = 1'b1;
                        ctrl[ctrlRegWrite] = 1'b1;
                        ctrl[ctrlMemRead]  = 1'b1;
                        ctrl[ctrlUseImm]   = 1'b1;
                end
                opSt: begin
                        useA               = 1'b1;
                        useB               = 1'b1;
                        ctrl[ctrlMemWrite] = 1'b1;
                        ctrl[ctrlUseImm]   = 1'b1;
                end
                opBeqz: begin
                        useA             = 1'b1;
                        imm              = imm8;
                        ctrl[ctrlBranch] = 1'b1;
                end
                default: begin
                        // unknown opcode stops the core like a halt
                        illegal        = 1'b1;
                        ctrl[ctrlHalt] = 1'b1;
                end
                endcase
        end

        // older writer still in flight
        function automatic logic pending(regIdxT r);
                return (exCtrl[ctrlRegWrite] && exRd == r) ||
                       (memWrShadow && memRdShadow == r) ||
                       (wbValid && wbReg == r);
        endfunction

        //////////////////////////////
        // interlock without forwarding
        always_comb begin
                stall = !flush && ((useA && pending(srcA)) || (useB && pending(srcB)));
        end

        // flushed words report nothing
        assign haltSeen  = ctrl[ctrlHalt] && !flush;
        assign illegalOp = illegal && !flush;

        // writeback port
        always_ff @(posedge clk) begin
                if (wbValid) begin
                        regs[wbReg] <= wbData;
                end
        end

        // ID/EX control with a bubble on flush or stall
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        exCtrl      <= '0;
                        memWrShadow <= 1'b0;
                end else begin
                        exCtrl      <= (flush || stall) ? '0 : ctrl;
                        memWrShadow <= exCtrl[ctrlRegWrite];
                end
        end

        // ID/EX payload
        always_ff @(posedge clk) begin
                exOpA       <= useA ? regs[srcA] : '0;
                exOpB       <= regs[srcB];
                exImm       <= imm;
                exPcNext    <= ifPcNext;
                exRd        <= dest;
                memRdShadow <= exRd;
        end

endmodule

//--- design/executeStage.sv
// execute stage: ALU, branch resolution, EX/MEM register
`timescale 1ns/1ns
module executeStage (
        input  logic                     clk,
        input  logic                     arstN,
        input  cpuPkg::wordT             exOpA,
        input  cpuPkg::wordT             exOpB,
        input  cpuPkg::wordT             exImm,
        input  cpuPkg::wordT             exPcNext,
        input  cpuPkg::regIdxT           exRd,
        input  logic [cpuPkg::CtrlW-1:0] exCtrl,
        output logic                     branchTaken,
        output cpuPkg::wordT             branchTarget,
        output cpuPkg::wordT             memAddr,
        output cpuPkg::wordT             memStoreData,
        output cpuPkg::regIdxT           memRd,
        output logic [cpuPkg::CtrlW-1:0] memCtrl
);
        import cpuPkg::*;

        wordT aluB;
        wordT aluOut;

        // second operand, register or immediate
        assign aluB   = exCtrl[ctrlUseImm] ? exImm : exOpB;
        assign aluOut = exCtrl[ctrlSub] ? exOpA - aluB : exOpA + aluB;

        //////////////////////////////
        // BEQZ, zero test on operand A
        assign branchTaken  = exCtrl[ctrlBranch] && (exOpA == '0);
        // relative to pc plus 2
        assign branchTarget = exPcNext + exImm;

        // EX/MEM control
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        memCtrl <= '0;
                end else begin
                        memCtrl <= exCtrl;
                end
        end

        // EX/MEM payload, result doubles as address
        always_ff @(posedge clk) begin
                memAddr      <= aluOut;
                memStoreData <= exOpB;
                memRd        <= exRd;
        end

        // decode bubbles ID/EX behind a taken branch
        assert property (@(posedge clk) disable iff (!arstN) branchTaken |=> !branchTaken)
                else $error("branch taken in the flushed slot");

endmodule

//--- design/fetchUnit.sv
// fetch stage: program counter, instruction memory with load port, IF/ID register
`timescale 1ns/1ns
module fetchUnit #(
        parameter int ImemWords = 64
) (
        input  logic         clk,
        input  logic         arstN,
        input  logic         fetchEn,
        input  logic         pcClear,
        input  logic         stall,
        input  logic         branchTaken,
        input  cpuPkg::wordT branchTarget,
        input  logic         imemWrEn,
        input  cpuPkg::wordT imemAddr,
        input  cpuPkg::wordT imemData,
        output cpuPkg::wordT ifInstr,
        output cpuPkg::wordT ifPcNext
);
        import cpuPkg::*;

        localparam int IAddrW = $clog2(ImemWords);

        wordT pc;
        wordT pcPlus2;
        wordT imem [ImemWords];

        // byte addressed, one word per step
        assign pcPlus2 = pc + 16'd2;

        // pc: clear, redirect, hold, advance
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        pc <= '0;
                end else if (pcClear) begin
                        pc <= '0;
                end else if (branchTaken) begin
                        pc <= branchTarget;
                end else if (fetchEn && !stall) begin
                        pc <= pcPlus2;
                end
        end

        // load port, byte address like the pc
        always_ff @(posedge clk) begin
                if (imemWrEn) begin
                        imem[imemAddr[IAddrW:1]] <= imemData;
                end
        end

        //////////////////////////////
        // IF/ID
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        ifInstr  <= nopWord;
                        ifPcNext <= '0;
                end else if (branchTaken) begin
                        // wrong-path word dropped
                        ifInstr <= nopWord;
                end else if (!stall) begin
                        ifInstr  <= fetchEn ? imem[pc[IAddrW:1]] : nopWord;
                        ifPcNext <= pcPlus2;
                end
        end

        // loads only while nothing is fetched
        assert property (@(posedge clk) disable iff (!arstN) imemWrEn |-> !fetchEn)
                else $error("instruction memory written while fetching");

endmodule

//--- design/memoryStage.sv
// memory stage: data memory, MEM/WB register, writeback select
`timescale 1ns/1ns
module memoryStage #(
        parameter int DmemWords = 32
) (
        input  logic                     clk,
        input  logic                     arstN,
        input  cpuPkg::wordT             memAddr,
        input  cpuPkg::wordT             memStoreData,
        input  cpuPkg::regIdxT           memRd,
        input  logic [cpuPkg::CtrlW-1:0] memCtrl,
        output logic                     wbValid,
        output cpuPkg::regIdxT           wbReg,
        output cpuPkg::wordT             wbData,
        output logic                     haltRetired
);
        import cpuPkg::*;

        localparam int DAddrW = $clog2(DmemWords);

        wordT              dmem [DmemWords];
        logic [DAddrW-1:0] dIdx;
        wordT              loadData;

        // word index, byte address bit 0 dropped
        assign dIdx     = memAddr[DAddrW:1];
        assign loadData = dmem[dIdx];

        always_ff @(posedge clk) begin
                if (memCtrl[ctrlMemWrite]) begin
                        dmem[dIdx] <= memStoreData;
                end
        end

        //////////////////////////////
        // MEM/WB, one pulse per register write
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        wbValid     <= 1'b0;
                        haltRetired <= 1'b0;
                end else begin
                        wbValid     <= memCtrl[ctrlRegWrite];
                        haltRetired <= memCtrl[ctrlHalt];
                end
        end

        // load data or ALU result
        always_ff @(posedge clk) begin
                wbReg  <= memRd;
                wbData <= memCtrl[ctrlMemRead] ? loadData : memAddr;
        end

        // address range on every access
        assert property (@(posedge clk) disable iff (!arstN)
                (memCtrl[ctrlMemRead] || memCtrl[ctrlMemWrite]) |-> memAddr[15:1] < DmemWords)
                else $error("data address out of range");

endmodule

//--- design/pipeCore.sv
// top level: five-stage core, stages and run control wired together
`timescale 1ns/1ns
module pipeCore #(
        parameter int ImemWords = 64,
        parameter int DmemWords = 32
) (
        input  logic           clk,
        input  logic           arstN,
        input  logic           start,
        input  logic           imemWrEn,
        input  cpuPkg::wordT   imemAddr,
        input  cpuPkg::wordT   imemData,
        output logic           running,
        output logic           halted,
        output logic           err,
        output logic           wbValid,
        output cpuPkg::regIdxT wbReg,
        output cpuPkg::wordT   wbData
);
        import cpuPkg::*;

        // run control
        logic             fetchEn;
        logic             pcClear;
        logic             haltSeen;
        logic             haltRetired;
        logic             illegalOp;
        // hazards and redirect
        logic             stall;
        logic             branchTaken;
        wordT             branchTarget;
        // IF/ID and ID/EX
        wordT             ifInstr;
        wordT             ifPcNext;
        wordT             exOpA;
        wordT             exOpB;
        wordT             exImm;
        wordT             exPcNext;
        regIdxT           exRd;
        logic [CtrlW-1:0] exCtrl;
        // EX/MEM
        wordT             memAddr;
        wordT             memStoreData;
        regIdxT           memRd;
        logic [CtrlW-1:0] memCtrl;

        runControl runControl_i (
                .clk, .arstN, .start, .haltSeen, .haltRetired, .illegalOp,
                .fetchEn, .pcClear, .running, .halted, .err
        );

        fetchUnit #(.ImemWords(ImemWords)) fetchUnit_i (
                .clk, .arstN, .fetchEn, .pcClear, .stall, .branchTaken, .branchTarget,
                .imemWrEn, .imemAddr, .imemData, .ifInstr, .ifPcNext
        );

        // writeback port loops back to the register file
        decodeStage decodeStage_i (
                .clk, .arstN, .ifInstr, .ifPcNext, .flush(branchTaken),
                .wbValid, .wbReg, .wbData, .stall, .haltSeen, .illegalOp,
                .exOpA, .exOpB, .exImm, .exPcNext, .exRd, .exCtrl
        );

        executeStage executeStage_i (
                .clk, .arstN, .exOpA, .exOpB, .exImm, .exPcNext, .exRd, .exCtrl,
                .branchTaken, .branchTarget, .memAddr, .memStoreData, .memRd, .memCtrl
        );

        memoryStage #(.DmemWords(DmemWords)) memoryStage_i (
                .clk, .arstN, .memAddr, .memStoreData, .memRd, .memCtrl,
                .wbValid, .wbReg, .wbData, .haltRetired
        );

endmodule

//--- design/runControl.sv
// run control: idle, run, drain and done FSM, sticky error flag
`timescale 1ns/1ns
module runControl (
        input  logic clk,
        input  logic arstN,
        input  logic start,
        input  logic haltSeen,
        input  logic haltRetired,
        input  logic illegalOp,
        output logic fetchEn,
        output logic pcClear,
        output logic running,
        output logic halted,
        output logic err
);
        localparam logic [1:0] sIdle  = 2'd0;
        localparam logic [1:0] sRun   = 2'd1;
        localparam logic [1:0] sDrain = 2'd2;
        localparam logic [1:0] sDone  = 2'd3;

        logic [1:0] state;
        logic [1:0] stateNext;
        logic       launch;

        // start ignored while a program runs
        assign launch  = start && (state == sIdle || state == sDone);
        assign pcClear = launch;
        // nothing past a halt gets fetched
        assign fetchEn = (state == sRun) && !haltSeen;
        assign running = (state == sRun) || (state == sDrain);
        assign halted  = (state == sDone);

        always_comb begin
                stateNext = state;
                case (state)
                sRun: begin
                        if (haltSeen) begin
                                stateNext = sDrain;
                        end
                end
                sDrain: begin
                        // wait for the halt to leave MEM/WB
                        if (haltRetired) begin
                                stateNext = sDone;
                        end
                end
                default: begin
                        if (launch) begin
                                stateNext = sRun;
                        end
                end
                endcase
        end

        //////////////////////////////
        // state and sticky error
        always_ff @(posedge clk or negedge arstN) begin
                if (!arstN) begin
                        state <= sIdle;
                        err   <= 1'b0;
                end else begin
                        state <= stateNext;
                        err   <= launch ? 1'b0 : (err | illegalOp);
                end
        end

        // pipeline empty while idle
        assert property (@(posedge clk) disable iff (!arstN) state == sIdle |-> !haltRetired)
                else $error("halt retired with no program running");

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the pipeCore testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pipeCoreTb -f tb.f -o simPipeCore

out=$(./obj_dir/simPipeCore)
echo "$out"
grep -qxF '*** PASSED ***' <<< "$out"

//--- tb.f
design/cpuPkg.sv
design/runControl.sv
design/fetchUnit.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/pipeCore.sv
tests/pipeCoreTb.sv

//--- tests/pipeCoreTb.sv
// testbench with golden-file programs, retirement monitor, watchdog and report
`timescale 1ns/1ns
module pipeCoreTb;

        logic        clk;
        logic        arstN;
        logic        start;
        logic        imemWrEn;
        logic [15:0] imemAddr;
        logic [15:0] imemData;
        logic        running;
        logic        halted;
        logic        err;
        logic        wbValid;
        logic [2:0]  wbReg;
        logic [15:0] wbData;

        // golden data of all tests back to back
        logic [15:0] progWords [$];
        int          progBase [$];
        int          progLen [$];
        logic [2:0]  expReg [$];
        logic [15:0] expVal [$];
        int          expBase [$];
        int          expLen [$];
        bit          expErr [$];

        int          fd;
        int          errors;
        int          retired;
        int          testErrors;
        int          timeoutNs;
        // monitor window of the running test
        bit          checking;
        int          curExpBase;
        int          curExpLen;
        int          seen;

        pipeCore #(.ImemWords(64), .DmemWords(32)) pipeCore_i (
                .clk, .arstN, .start, .imemWrEn, .imemAddr, .imemData,
                .running, .halted, .err, .wbValid, .wbReg, .wbData
        );

        // 8 ns period
        initial clk = 1'b0;
        always #4 clk = ~clk;

        //////////////////////////////
        // golden file parsing
        function automatic int nextTag();
                int ch;
                ch = $fgetc(fd);
                // blanks and # comments skipped
                while (ch == " " || ch == "\t" || ch == "\n" || ch == "\r" || ch == "#") begin
                        if (ch == "#") begin
                                while (ch != "\n" && ch != -1) begin
                                        ch = $fgetc(fd);
                                end
                        end
                        ch = $fgetc(fd);
                end
                return ch;
        endfunction

        function automatic bit readGolden();
                int          tag;
                int          cnt;
                int          n;
                int          i;
                int          r;
                logic [15:0] w;
                bit          ok;
                fd = $fopen("tests/program_golden.txt", "r");
                if (fd == 0) begin
                        return 1'b0;
                end
                ok  = 1'b1;
                tag = nextTag();
                while (tag != -1 && ok) begin
                        case (tag)
                        "P": begin
                                n  = $fscanf(fd, "%d", cnt);
                                ok = (n == 1);
                                progBase.push_back(progWords.size());
                                progLen.push_back(cnt);
                                for (i = 0; i < cnt && ok; i++) begin
                                        n  = $fscanf(fd, "%h", w);
                                        ok = (n == 1);
                                        progWords.push_back(w);
                                end
                        end
                        "R": begin
                                n  = $fscanf(fd, "%d", cnt);
                                ok = (n == 1);
                                expBase.push_back(expReg.size());
                                expLen.push_back(cnt);
                                // register and value pairs
                                for (i = 0; i < cnt && ok; i++) begin
                                        n  = $fscanf(fd, "%d %h", r, w);
                                        ok = (n == 2);
                                        expReg.push_back(r[2:0]);
                                        expVal.push_back(w);
                                end
                        end
                        "E": begin
                                // first letter tells halt from error
                                tag = nextTag();
                                expErr.push_back(tag == "e");
                                while (tag != "\n" && tag != -1) begin
                                        tag = $fgetc(fd);
                                end
                        end
                        default: begin
                                ok = 1'b0;
                        end
                        endcase
                        tag = nextTag();
                end
                $fclose(fd);
                // every test needs all three parts
                return ok && progLen.size() > 0 && progLen.size() == expLen.size() &&
                       progLen.size() == expErr.size();
        endfunction

        //////////////////////////////
        // retirement monitor sampled mid-cycle
        always @(negedge clk) begin
                if (wbValid) begin
                        if (!checking || seen >= curExpLen) begin
                                $display("Error at %0t ns: unexpected retirement r%0d=%h",
                                         $time, wbReg, wbData);
                                testErrors++;
                        end else if (wbReg != expReg[curExpBase + seen] ||
                                     wbData != expVal[curExpBase + seen]) begin
                                $display("Error at %0t ns: r%0d=%h retired, expected r%0d=%h",
                                         $time, wbReg, wbData,
                                         expReg[curExpBase + seen], expVal[curExpBase + seen]);
                                testErrors++;
                        end
                        seen++;
                        retired++;
                end
        end

        // one program from load and start through the halt to its end state
        task automatic runTest(input int t);
                int gap;
                int i;
                testErrors = 0;
                gap = $urandom % 4;
                repeat (gap) @(posedge clk);
                // words at byte addresses 0, 2, 4 ...
                for (i = 0; i < progLen[t]; i++) begin
                        @(posedge clk);
                        #1;
                        imemWrEn = 1'b1;
                        imemAddr = 16'(2 * i);
                        imemData = progWords[progBase[t] + i];
                end
                curExpBase = expBase[t];
                curExpLen  = expLen[t];
                seen       = 0;
                checking   = 1'b1;
                @(posedge clk);
                #1;
                imemWrEn = 1'b0;
                start    = 1'b1;
                @(posedge clk);
                #1;
                start = 1'b0;
                // start clears a sticky err
                if (err || !running) begin
                        $display("Error at %0t ns: after start err=%0b running=%0b",
                                 $time, err, running);
                        testErrors++;
                end
                while (!halted) begin
                        @(posedge clk);
                        #1;
                end
                // quiet window where no retirement may follow the halt
                repeat (6) @(posedge clk);
                #1;
                checking = 1'b0;
                if (seen != curExpLen) begin
                        $display("Error at %0t ns: %0d retirements, expected %0d",
                                 $time, seen, curExpLen);
                        testErrors++;
                end
                if (!halted || err != expErr[t]) begin
                        $display("Error at %0t ns: halted=%0b err=%0b, expected err=%0b",
                                 $time, halted, err, expErr[t]);
                        testErrors++;
                end
                errors += testErrors;
                $display("test %0d: %0d words, %0d retirements, %0d errors",
                         t, progLen[t], seen, testErrors);
        endtask

        //////////////////////////////
        // watchdog scaled by total program size
        initial begin
                wait (timeoutNs > 0);
                #(timeoutNs);
                $display("Timeout: programs still running after %0d ns", timeoutNs);
                $display("*** FAILED ***");
                $finish;
        end

        initial begin
                int t;
                arstN      = 1'b0;
                start      = 1'b0;
                imemWrEn   = 1'b0;
                imemAddr   = '0;
                imemData   = '0;
                errors     = 0;
                retired    = 0;
                testErrors = 0;
                checking   = 1'b0;
                curExpBase = 0;
                curExpLen  = 0;
                seen       = 0;
                timeoutNs  = 0;
                void'($urandom(32'hdfe7));
                if (!readGolden()) begin
                        $display("Golden file tests/program_golden.txt missing or malformed");
                        $display("*** FAILED ***");
                        $finish;
                end else begin
                        // 12 cycles of 8 ns per program word
                        timeoutNs = progWords.size() * 12 * 8 + 400;
                        repeat (2) @(posedge clk);
                        #1 arstN = 1'b1;
                        for (t = 0; t < progLen.size(); t++) begin
                                runTest(t);
                        end
                        $display("tests %0d, retirements %0d, errors %0d",
                                 progLen.size(), retired, errors);
                        if (errors == 0) begin
                                $display("*** PASSED ***");
                        end else begin
                                $display("*** FAILED ***");
                        end
                        $finish;
                end
        end

endmodule

//--- tests/program_golden.txt
# P <n> <n hex words>          program, loaded from byte address 0
# R <n> <n pairs: reg hex>     expected retirements in program order
# E halt|error                 expected end state
# LBI, ADDI, ADD, SUB with sign extension, dependent chain
P 7 c105 c2fd 4167 d950 da75 45d0 0000
R 6 1 0005 2 fffd 3 000c 4 0002 5 fff1 6 ffe1
E halt
# store then load at 0x16, load-use add
P 6 c112 c29c 8144 8964 db30 0000
R 4 1 0012 2 ff9c 3 ff9c 4 ffae
E halt
# taken BEQZ skips two words, untaken BEQZ falls through
P 9 c100 c201 6104 c333 c444 6202 c555 45c1 0000
R 4 1 0000 2 0001 5 0055 6 0056
E halt
# unknown opcode 01111 stops the core, err set
P 3 c107 7800 c209
R 1 1 0007
E error
# restart after the error, err cleared
P 4 c780 dfe0 d8e5 0000
R 3 7 ff80 0 ff00 1 ff80
E halt
